/* Makefile */
# Verilator build for the load/store unit testbench.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= flist.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

FAIL_MSG  := tests failed
PASS_MSG  := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/lsu_tb.sv */
// Directed testbench for the load/store unit and its on-chip memory.
// The memory is not cleared on reset, so a 16-word window is written before any load.
// Every access is checked against a reference memory and the fixed latencies.
// The run stops at the first mismatch or timeout.
module lsu_tb;

    localparam int WAIT_LIMIT   = 20;
    localparam int WINDOW_WORDS = 16;

    logic clk;
    logic rst_n;
    logic int_assert_i;
    logic req_mem_i;
    lsu_pkg::mem_op_e mem_op_i;
    logic [lsu_pkg::REG_ADDR_W-1:0] rd_addr_i;
    logic [axi_pkg::ADDR_W-1:0] mem_addr_i;
    logic [lsu_pkg::REG_DATA_W-1:0] mem_wdata_i;
    logic [lsu_pkg::REG_STRB_W-1:0] mem_wmask_i;
    logic [lsu_pkg::COMMIT_ID_W-1:0] commit_id_i;
    logic mem_stall_o;
    logic reg_we_o;
    logic [lsu_pkg::REG_ADDR_W-1:0] reg_waddr_o;
    logic [lsu_pkg::REG_DATA_W-1:0] reg_wdata_o;
    logic [lsu_pkg::COMMIT_ID_W-1:0] commit_id_o;

    // reference memory, one 64-bit word per index
    logic [63:0] ref_mem [axi_pkg::SRAM_WORDS];
    logic [31:0] rng_state;
    string test_name;

    // what the last watched request did
    int stall_cycles;
    int we_count;
    int we_at;
    logic [31:0] wb_data;
    logic [4:0] wb_waddr;
    logic [2:0] wb_cid;

    lsu_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .int_assert_i (int_assert_i),
        .req_mem_i    (req_mem_i),
        .mem_op_i     (mem_op_i),
        .rd_addr_i    (rd_addr_i),
        .mem_addr_i   (mem_addr_i),
        .mem_wdata_i  (mem_wdata_i),
        .mem_wmask_i  (mem_wmask_i),
        .commit_id_i  (commit_id_i),
        .mem_stall_o  (mem_stall_o),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .reg_wdata_o  (reg_wdata_o),
        .commit_id_o  (commit_id_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ======================================================================
    // helpers
    // ======================================================================
    task automatic stop_run(string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("ERROR %s: %s expected %h actual %h",
                               test_name, what, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // preload pattern, every address bit matters
    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
    endfunction

    // index wraps at bit 10, bit 2 picks the lane
    function automatic void apply_store_to_model(logic [31:0] addr, logic [31:0] wdata,
                                                 logic [3:0] wmask);
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) begin
                ref_mem[addr[10:3]][32 * int'(addr[2]) + 8 * b +: 8] = wdata[8 * b +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] predict_load(lsu_pkg::mem_op_e op, logic [31:0] addr);
        logic [31:0] word;
        logic [7:0] byte_v;
        logic [15:0] half_v;
        word   = ref_mem[addr[10:3]][32 * int'(addr[2]) +: 32];
        byte_v = word[8 * int'(addr[1:0]) +: 8];
        half_v = word[16 * int'(addr[1]) +: 16];
        case (op)
            lsu_pkg::OP_LB:  return 32'($signed(byte_v));
            lsu_pkg::OP_LBU: return {24'h0, byte_v};
            lsu_pkg::OP_LH:  return 32'($signed(half_v));
            lsu_pkg::OP_LHU: return {16'h0, half_v};
            default:         return word;
        endcase
    endfunction

    // strobe for one cycle, returns right after the accepting edge
    task automatic send_request(lsu_pkg::mem_op_e op, logic [31:0] addr, logic [31:0] wdata,
                                logic [3:0] wmask, logic [4:0] rd, logic [2:0] cid);
        @(posedge clk);
        req_mem_i   <= 1'b1;
        mem_op_i    <= op;
        mem_addr_i  <= addr;
        mem_wdata_i <= wdata;
        mem_wmask_i <= wmask;
        rd_addr_i   <= rd;
        commit_id_i <= cid;
        @(posedge clk);
        req_mem_i <= 1'b0;
    endtask

    // follows one request until mem_stall_o falls
    task automatic watch_request();
        int cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        stall_cycles = 0;
        we_count = 0;
        we_at = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (reg_we_o) begin
                we_count++;
                we_at    = cycles;
                wb_data  = reg_wdata_o;
                wb_waddr = reg_waddr_o;
                wb_cid   = commit_id_o;
            end
            if (mem_stall_o) begin
                stall_cycles++;
            end else begin
                done = 1'b1;
            end
            if (!done && cycles >= WAIT_LIMIT) begin
                stop_run($sformatf("%s: mem_stall_o did not fall within %0d cycles",
                                   test_name, WAIT_LIMIT));
            end
        end
    endtask

    task automatic store_and_check(logic [31:0] addr, logic [31:0] wdata, logic [3:0] wmask);
        send_request(lsu_pkg::OP_STORE, addr, wdata, wmask, 5'd0, 3'd0);
        watch_request();
        check_value("store stall cycles", 32'd3, stall_cycles);
        check_value("store writebacks", 32'd0, we_count);
        apply_store_to_model(addr, wdata, wmask);
    endtask

    task automatic load_and_check(lsu_pkg::mem_op_e op, logic [31:0] addr, logic [4:0] rd,
                                  logic [2:0] cid);
        send_request(op, addr, 32'h0, 4'h0, rd, cid);
        watch_request();
        check_value("load stall cycles", 32'd2, stall_cycles);
        check_value("load writebacks", 32'd1, we_count);
        check_value("writeback cycle", 32'd2, we_at);
        check_value("load data", predict_load(op, addr), wb_data);
        check_value("reg_waddr_o", 32'(rd), 32'(wb_waddr));
        check_value("commit_id_o", 32'(cid), 32'(wb_cid));
    endtask

    task automatic expect_idle_cycles(int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("mem_stall_o while idle", 32'd0, 32'(mem_stall_o));
            check_value("reg_we_o while idle", 32'd0, 32'(reg_we_o));
        end
    endtask

    task automatic preload_window();
        logic [31:0] addr;
        test_name = "preload_window";
        for (int i = 0; i < 2 * WINDOW_WORDS; i++) begin
            addr = 32'(i * 4);
            store_and_check(addr, fill_word(addr), 4'hF);
        end
    endtask

    // ======================================================================
    // directed tests
    // ======================================================================
    task automatic word_round_trip();
        test_name = "word_round_trip";
        store_and_check(32'h0000_0010, 32'h1234_5678, 4'hF);
        store_and_check(32'h0000_0014, 32'h9ABC_DEF0, 4'hF);
        load_and_check(lsu_pkg::OP_LW, 32'h0000_0010, 5'd3, 3'd1);
        load_and_check(lsu_pkg::OP_LW, 32'h0000_0014, 5'd17, 3'd6);
        // 0x820 and 0x1024 alias the words at 0x20 and 0x24
        store_and_check(32'h0000_0820, 32'hCAFE_0001, 4'hF);
        load_and_check(lsu_pkg::OP_LW, 32'h0000_0020, 5'd31, 3'd7);
        check_value("aliased lower word", 32'hCAFE_0001, wb_data);
        store_and_check(32'h0000_0024, 32'h0BAD_F00D, 4'hF);
        load_and_check(lsu_pkg::OP_LW, 32'h0000_1024, 5'd1, 3'd0);
        check_value("aliased upper word", 32'h0BAD_F00D, wb_data);
    endtask

    task automatic masked_stores();
        test_name = "masked_stores";
        store_and_check(32'h0000_0031, 32'h0000_AB00, 4'b0010);
        load_and_check(lsu_pkg::OP_LW, 32'h0000_0030, 5'd2, 3'd2);
        store_and_check(32'h0000_0036, 32'h1234_0000, 4'b1100);
        load_and_check(lsu_pkg::OP_LW, 32'h0000_0034, 5'd6, 3'd3);
        store_and_check(32'h0000_003B, 32'h5500_0000, 4'b1000);
        store_and_check(32'h0000_0038, 32'h0000_00EE, 4'b0001);
        load_and_check(lsu_pkg::OP_LW, 32'h0000_0038, 5'd10, 3'd4);
        store_and_check(32'h0000_003C, 32'h00C0_FF00, 4'b0110);
        load_and_check(lsu_pkg::OP_LW, 32'h0000_003C, 5'd11, 3'd5);
    endtask

    task automatic load_extraction();
        logic [31:0] addr;
        test_name = "load_extraction";
        // sign bits set and clear in both lanes
        store_and_check(32'h0000_0040, 32'h80FF_7F01, 4'hF);
        store_and_check(32'h0000_0044, 32'hFE7F_8081, 4'hF);
        for (int lane = 0; lane < 2; lane++) begin
            for (int off = 0; off < 4; off++) begin
                addr = 32'h0000_0040 + 32'(4 * lane + off);
                load_and_check(lsu_pkg::OP_LB, addr, 5'(off + 8), 3'(off));
                load_and_check(lsu_pkg::OP_LBU, addr, 5'(off + 12), 3'(off + 4));
                if (off % 2 == 0) begin
                    load_and_check(lsu_pkg::OP_LH, addr, 5'(off + 16), 3'(lane));
                    load_and_check(lsu_pkg::OP_LHU, addr, 5'(off + 20), 3'(lane + 2));
                end
            end
        end
    endtask

    task automatic timing_and_drops();
        test_name = "timing_and_drops";
        store_and_check(32'h0000_0050, 32'h1111_2222, 4'hF);

        // store strobed in the middle of a load
        send_request(lsu_pkg::OP_LW, 32'h0000_0054, 32'h0, 4'h0, 5'd9, 3'd4);
        fork
            watch_request();
            send_request(lsu_pkg::OP_STORE, 32'h0000_0050, 32'hDEAD_BEEF, 4'hF, 5'd0, 3'd0);
        join
        check_value("load stall cycles", 32'd2, stall_cycles);
        check_value("load writebacks", 32'd1, we_count);
        check_value("writeback cycle", 32'd2, we_at);
        check_value("load data", predict_load(lsu_pkg::OP_LW, 32'h0000_0054), wb_data);
        check_value("reg_waddr_o", 32'd9, 32'(wb_waddr));
        check_value("commit_id_o", 32'd4, 32'(wb_cid));
        expect_idle_cycles(2);

        // load strobed in the middle of a store
        send_request(lsu_pkg::OP_STORE, 32'h0000_0058, 32'h3333_4444, 4'hF, 5'd0, 3'd0);
        fork
            watch_request();
            send_request(lsu_pkg::OP_LW, 32'h0000_0050, 32'h0, 4'h0, 5'd12, 3'd5);
        join
        check_value("store stall cycles", 32'd3, stall_cycles);
        check_value("store writebacks", 32'd0, we_count);
        apply_store_to_model(32'h0000_0058, 32'h3333_4444, 4'hF);
        expect_idle_cycles(2);

        load_and_check(lsu_pkg::OP_LW, 32'h0000_0050, 5'd13, 3'd6);
        check_value("word after dropped store", 32'h1111_2222, wb_data);
        load_and_check(lsu_pkg::OP_LW, 32'h0000_0058, 5'd14, 3'd7);
    endtask

    task automatic interrupt_block();
        test_name = "interrupt_block";
        @(posedge clk);
        int_assert_i <= 1'b1;
        send_request(lsu_pkg::OP_STORE, 32'h0000_0060, 32'h7777_7777, 4'hF, 5'd0, 3'd0);
        expect_idle_cycles(3);
        send_request(lsu_pkg::OP_LW, 32'h0000_0060, 32'h0, 4'h0, 5'd4, 3'd2);
        expect_idle_cycles(3);
        @(posedge clk);
        int_assert_i <= 1'b0;
        load_and_check(lsu_pkg::OP_LW, 32'h0000_0060, 5'd5, 3'd3);
        check_value("word after blocked store", fill_word(32'h0000_0060), wb_data);
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] wdata;
        test_name = "random_mix";
        for (int i = 0; i < 200; i++) begin
            rng_state = xorshift32(rng_state);
            r = rng_state;
            // word in the window, bits 12:11 alias through the wrap
            addr = {19'd0, r[12:11], 4'd0, r[6:2], 2'b00};
            case (r[15:13])
                3'd0, 3'd1, 3'd2: begin
                    rng_state = xorshift32(rng_state);
                    wdata = rng_state;
                    store_and_check(addr, wdata, r[19:16]);
                end
                3'd3: load_and_check(lsu_pkg::OP_LB, addr | 32'(r[1:0]), r[24:20], r[27:25]);
                3'd4: load_and_check(lsu_pkg::OP_LBU, addr | 32'(r[1:0]), r[24:20], r[27:25]);
                3'd5: load_and_check(lsu_pkg::OP_LH, addr | {30'd0, r[1], 1'b0}, r[24:20],
                                     r[27:25]);
                3'd6: load_and_check(lsu_pkg::OP_LHU, addr | {30'd0, r[1], 1'b0}, r[24:20],
                                     r[27:25]);
                default: load_and_check(lsu_pkg::OP_LW, addr, r[24:20], r[27:25]);
            endcase
        end
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        rng_state = 32'd26812;
        test_name = "reset";
        rst_n        <= 1'b0;
        int_assert_i <= 1'b0;
        req_mem_i    <= 1'b0;
        mem_op_i     <= lsu_pkg::OP_LW;
        rd_addr_i    <= '0;
        mem_addr_i   <= '0;
        mem_wdata_i  <= '0;
        mem_wmask_i  <= '0;
        commit_id_i  <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("mem_stall_o after reset", 32'd0, 32'(mem_stall_o));
        check_value("reg_we_o after reset", 32'd0, 32'(reg_we_o));

        preload_window();
        word_round_trip();
        masked_stores();
        load_extraction();
        timing_and_drops();
        interrupt_block();
        random_mix();

        $display("all tests passed");
        $finish;
    end

endmodule

/* flist.f */
hdl/lsu_pkg.sv
hdl/axi_pkg.sv
hdl/lsu_lane_align.sv
hdl/lsu_unit.sv
hdl/axi_sram.sv
hdl/lsu_top.sv
bench/lsu_tb.sv

/* hdl/axi_pkg.sv */
// Bus and memory definitions for the single-beat 64-bit AXI link.
// Only valid, ready, address, data and strobe exist on the link.
// The memory decodes address bits 10:3; higher bits alias.
package axi_pkg;

    // ======================================================================
    // bus widths
    // ======================================================================
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 64;
    localparam int unsigned STRB_W = DATA_W / 8;

    // two 32-bit lanes per beat
    localparam int unsigned LANE_W = DATA_W / 2;

    // ======================================================================
    // on-chip memory
    // ======================================================================
    localparam int unsigned SRAM_WORDS = 256;
    localparam int unsigned SRAM_IDX_W = $clog2(SRAM_WORDS);

    // first address bit above the byte offset within a beat
    localparam int unsigned WORD_LSB = $clog2(STRB_W);

    // one beat, seen as lanes by the load path and as bytes by the memory
    typedef union packed {
        logic [1:0][LANE_W-1:0] lanes;
        logic [STRB_W-1:0][7:0] bytes;
    } bus_word_u;

endpackage

/* hdl/axi_sram.sv */
// Single-beat AXI slave memory, one read or one write in flight.
// Contents are not cleared on reset. Reads win if ar and aw arrive together.
// r_valid and b_valid rise the cycle after the ar or w handshake.
module axi_sram (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic [axi_pkg::ADDR_W-1:0]   ar_addr_i,
    input  logic                         ar_valid_i,
    output logic                         ar_ready_o,
    output logic [axi_pkg::DATA_W-1:0]   r_data_o,
    output logic                         r_valid_o,
    input  logic                         r_ready_i,

    input  logic [axi_pkg::ADDR_W-1:0]   aw_addr_i,
    input  logic                         aw_valid_i,
    output logic                         aw_ready_o,
    input  logic [axi_pkg::DATA_W-1:0]   w_data_i,
    input  logic [axi_pkg::STRB_W-1:0]   w_strb_i,
    input  logic                         w_valid_i,
    output logic                         w_ready_o,
    output logic                         b_valid_o,
    input  logic                         b_ready_i
);

    axi_pkg::bus_word_u mem_q [axi_pkg::SRAM_WORDS];
    axi_pkg::bus_word_u w_word;

    logic [axi_pkg::SRAM_IDX_W-1:0] ar_idx;
    logic [axi_pkg::SRAM_IDX_W-1:0] aw_idx_q;
    logic aw_pending_q;
    logic busy;
    logic ar_hs;
    logic aw_hs;
    logic w_hs;

    assign busy = r_valid_o || aw_pending_q || b_valid_o;

    // ready while free, aw held back if a read is offered too
    assign ar_ready_o = !busy;
    assign aw_ready_o = !busy && !ar_valid_i;
    assign w_ready_o  = aw_pending_q;

    assign ar_hs = ar_valid_i && ar_ready_o;
    assign aw_hs = aw_valid_i && aw_ready_o;
    assign w_hs  = w_valid_i && w_ready_o;

    assign ar_idx = ar_addr_i[axi_pkg::WORD_LSB +: axi_pkg::SRAM_IDX_W];
    assign w_word = w_data_i;

    // ======================================================================
    // channel control
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid_o    <= 1'b0;
            aw_pending_q <= 1'b0;
            b_valid_o    <= 1'b0;
        end else begin
            if (ar_hs) begin
                r_valid_o <= 1'b1;
            end else if (r_ready_i) begin
                r_valid_o <= 1'b0;
            end

            if (aw_hs) begin
                aw_pending_q <= 1'b1;
            end else if (w_hs) begin
                aw_pending_q <= 1'b0;
            end

            if (w_hs) begin
                b_valid_o <= 1'b1;
            end else if (b_ready_i) begin
                b_valid_o <= 1'b0;
            end
        end
    end

    // ======================================================================
    // storage
    // ======================================================================
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            r_data_o <= mem_q[ar_idx];
        end
        if (aw_hs) begin
            aw_idx_q <= aw_addr_i[axi_pkg::WORD_LSB +: axi_pkg::SRAM_IDX_W];
        end
        // byte writes under strobe
        if (w_hs) begin
            for (int i = 0; i < axi_pkg::STRB_W; i++) begin
                if (w_strb_i[i]) begin
                    mem_q[aw_idx_q].bytes[i] <= w_word.bytes[i];
                end
            end
        end
    end

endmodule

/* hdl/lsu_lane_align.sv */
// Lane placement between the 32-bit request side and the 64-bit bus.
// Store data must already sit at its byte position inside the word.
// The read side is purely combinational on the captured operation and offset.
module lsu_lane_align (
    // write side
    input  logic [axi_pkg::ADDR_W-1:0]       mem_addr_i,
    input  logic [lsu_pkg::REG_DATA_W-1:0]   mem_wdata_i,
    input  logic [lsu_pkg::REG_STRB_W-1:0]   mem_wmask_i,
    output logic [axi_pkg::DATA_W-1:0]       w_data_o,
    output logic [axi_pkg::STRB_W-1:0]       w_strb_o,

    // read side
    input  lsu_pkg::mem_op_e                 rd_op_i,
    input  logic [2:0]                       rd_offset_i,
    input  logic [axi_pkg::DATA_W-1:0]       r_data_i,
    output logic [lsu_pkg::REG_DATA_W-1:0]   load_data_o
);

    axi_pkg::bus_word_u r_word;
    logic [lsu_pkg::REG_DATA_W-1:0] lane;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;

    // ======================================================================
    // write lane placement
    // ======================================================================

    // same word on both lanes, strobes pick the one that lands
    assign w_data_o = {mem_wdata_i, mem_wdata_i};

    assign w_strb_o = mem_addr_i[2] ? {mem_wmask_i, {lsu_pkg::REG_STRB_W{1'b0}}}
                                    : {{lsu_pkg::REG_STRB_W{1'b0}}, mem_wmask_i};

    // ======================================================================
    // load extraction
    // ======================================================================
    assign r_word = r_data_i;

    // bit 2 of the offset chooses the upper lane
    assign lane = r_word.lanes[rd_offset_i[2]];

    assign byte_sel = lane[8 * rd_offset_i[1:0] +: 8];
    assign half_sel = rd_offset_i[1] ? lane[31:16] : lane[15:0];

    always_comb begin
        case (rd_op_i)
            lsu_pkg::OP_LB: begin
                load_data_o = {{24{byte_sel[7]}}, byte_sel};
            end
            lsu_pkg::OP_LBU: begin
                load_data_o = {24'h0, byte_sel};
            end
            lsu_pkg::OP_LH: begin
                load_data_o = {{16{half_sel[15]}}, half_sel};
            end
            lsu_pkg::OP_LHU: begin
                load_data_o = {16'h0, half_sel};
            end
            lsu_pkg::OP_LW: begin
                load_data_o = lane;
            end
            // stores never write back
            default: begin
                load_data_o = '0;
            end
        endcase
    end

endmodule

/* hdl/lsu_pkg.sv */
// Load/store request definitions shared by the unit, the top level and the bench.
// Only the five RV32 load forms and one masked word store are encoded.
// Misaligned requests are not detected here or anywhere downstream.
package lsu_pkg;

    // ======================================================================
    // register file side
    // ======================================================================

    // destination register index
    localparam int unsigned REG_ADDR_W = 5;

    // register and request data width
    localparam int unsigned REG_DATA_W = 32;

    // byte enables for one register word
    localparam int unsigned REG_STRB_W = REG_DATA_W / 8;

    // tag handed back with a load result
    localparam int unsigned COMMIT_ID_W = 3;

    // ======================================================================
    // operation encoding
    // ======================================================================
    typedef enum logic [2:0] {
        OP_LB    = 3'd0,
        OP_LH    = 3'd1,
        OP_LW    = 3'd2,
        OP_LBU   = 3'd3,
        OP_LHU   = 3'd4,
        OP_STORE = 3'd5
    } mem_op_e;

endpackage

/* hdl/lsu_top.sv */
// Load/store unit paired with its on-chip memory.
// The memory is always ready when free, so load and store latencies are fixed.
module lsu_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              int_assert_i,
    input  logic                              req_mem_i,
    input  lsu_pkg::mem_op_e                  mem_op_i,
    input  logic [lsu_pkg::REG_ADDR_W-1:0]    rd_addr_i,
    input  logic [axi_pkg::ADDR_W-1:0]        mem_addr_i,
    input  logic [lsu_pkg::REG_DATA_W-1:0]    mem_wdata_i,
    input  logic [lsu_pkg::REG_STRB_W-1:0]    mem_wmask_i,
    input  logic [lsu_pkg::COMMIT_ID_W-1:0]   commit_id_i,
    output logic                              mem_stall_o,
    output logic                              reg_we_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0]    reg_waddr_o,
    output logic [lsu_pkg::REG_DATA_W-1:0]    reg_wdata_o,
    output logic [lsu_pkg::COMMIT_ID_W-1:0]   commit_id_o
);

    // internal AXI link
    logic [axi_pkg::ADDR_W-1:0] ar_addr;
    logic ar_valid;
    logic ar_ready;
    logic [axi_pkg::DATA_W-1:0] r_data;
    logic r_valid;
    logic r_ready;
    logic [axi_pkg::ADDR_W-1:0] aw_addr;
    logic aw_valid;
    logic aw_ready;
    logic [axi_pkg::DATA_W-1:0] w_data;
    logic [axi_pkg::STRB_W-1:0] w_strb;
    logic w_valid;
    logic w_ready;
    logic b_valid;
    logic b_ready;

    lsu_unit u_lsu (
        .clk          (clk),
        .rst_n        (rst_n),
        .int_assert_i (int_assert_i),
        .req_mem_i    (req_mem_i),
        .mem_op_i     (mem_op_i),
        .rd_addr_i    (rd_addr_i),
        .mem_addr_i   (mem_addr_i),
        .mem_wdata_i  (mem_wdata_i),
        .mem_wmask_i  (mem_wmask_i),
        .commit_id_i  (commit_id_i),
        .mem_stall_o  (mem_stall_o),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .reg_wdata_o  (reg_wdata_o),
        .commit_id_o  (commit_id_o),
        .ar_addr_o    (ar_addr),
        .ar_valid_o   (ar_valid),
        .ar_ready_i   (ar_ready),
        .r_data_i     (r_data),
        .r_valid_i    (r_valid),
        .r_ready_o    (r_ready),
        .aw_addr_o    (aw_addr),
        .aw_valid_o   (aw_valid),
        .aw_ready_i   (aw_ready),
        .w_data_o     (w_data),
        .w_strb_o     (w_strb),
        .w_valid_o    (w_valid),
        .w_ready_i    (w_ready),
        .b_valid_i    (b_valid),
        .b_ready_o    (b_ready)
    );

    axi_sram u_sram (
        .clk        (clk),
        .rst_n      (rst_n),
        .ar_addr_i  (ar_addr),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .r_data_o   (r_data),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .aw_addr_i  (aw_addr),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .w_data_i   (w_data),
        .w_strb_i   (w_strb),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready)
    );

endmodule

/* hdl/lsu_unit.sv */
// Single-request load/store unit with a 64-bit single-beat AXI master.
// A request is taken only when idle and no interrupt is pending; others are dropped.
// One channel is driven at a time, so a load takes two cycles and a store three
// against a slave that is always ready.
module lsu_unit (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              int_assert_i,

    // request strobe, no back-pressure
    input  logic                              req_mem_i,
    input  lsu_pkg::mem_op_e                  mem_op_i,
    input  logic [lsu_pkg::REG_ADDR_W-1:0]    rd_addr_i,
    input  logic [axi_pkg::ADDR_W-1:0]        mem_addr_i,
    input  logic [lsu_pkg::REG_DATA_W-1:0]    mem_wdata_i,
    input  logic [lsu_pkg::REG_STRB_W-1:0]    mem_wmask_i,
    input  logic [lsu_pkg::COMMIT_ID_W-1:0]   commit_id_i,

    output logic                              mem_stall_o,

    // register writeback
    output logic                              reg_we_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0]    reg_waddr_o,
    output logic [lsu_pkg::REG_DATA_W-1:0]    reg_wdata_o,
    output logic [lsu_pkg::COMMIT_ID_W-1:0]   commit_id_o,

    // AXI master
    output logic [axi_pkg::ADDR_W-1:0]        ar_addr_o,
    output logic                              ar_valid_o,
    input  logic                              ar_ready_i,
    input  logic [axi_pkg::DATA_W-1:0]        r_data_i,
    input  logic                              r_valid_i,
    output logic                              r_ready_o,
    output logic [axi_pkg::ADDR_W-1:0]        aw_addr_o,
    output logic                              aw_valid_o,
    input  logic                              aw_ready_i,
    output logic [axi_pkg::DATA_W-1:0]        w_data_o,
    output logic [axi_pkg::STRB_W-1:0]        w_strb_o,
    output logic                              w_valid_o,
    input  logic                              w_ready_i,
    input  logic                              b_valid_i,
    output logic                              b_ready_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RADDR,
        ST_RDATA,
        ST_WADDR,
        ST_WDATA,
        ST_WRESP
    } state_e;

    state_e state_q;
    state_e state_d;
    logic accept;

    // captured request
    lsu_pkg::mem_op_e op_q;
    logic [lsu_pkg::REG_ADDR_W-1:0] rd_q;
    logic [lsu_pkg::COMMIT_ID_W-1:0] commit_q;
    logic [2:0] offset_q;
    logic [axi_pkg::ADDR_W-1:0] addr_q;
    logic [lsu_pkg::REG_DATA_W-1:0] wdata_q;
    logic [lsu_pkg::REG_STRB_W-1:0] wmask_q;

    assign accept = (state_q == ST_IDLE) && req_mem_i && !int_assert_i;

    // ======================================================================
    // request capture
    // ======================================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= mem_op_i;
            rd_q     <= rd_addr_i;
            commit_q <= commit_id_i;
            offset_q <= mem_addr_i[2:0];
            addr_q   <= {mem_addr_i[axi_pkg::ADDR_W-1:2], 2'b00};
            // store data held so the w beat sees a stable word
            wdata_q  <= mem_wdata_i;
            wmask_q  <= mem_wmask_i;
        end
    end

    // ======================================================================
    // AXI master FSM
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = (mem_op_i == lsu_pkg::OP_STORE) ? ST_WADDR : ST_RADDR;
                end
            end
            ST_RADDR: if (ar_ready_i) state_d = ST_RDATA;
            ST_RDATA: if (r_valid_i)  state_d = ST_IDLE;
            ST_WADDR: if (aw_ready_i) state_d = ST_WDATA;
            ST_WDATA: if (w_ready_i)  state_d = ST_WRESP;
            ST_WRESP: if (b_valid_i)  state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    // channel controls follow the state directly
    assign ar_valid_o = (state_q == ST_RADDR);
    assign r_ready_o  = (state_q == ST_RDATA);
    assign aw_valid_o = (state_q == ST_WADDR);
    assign w_valid_o  = (state_q == ST_WDATA);
    assign b_ready_o  = (state_q == ST_WRESP);

    assign ar_addr_o = addr_q;
    assign aw_addr_o = addr_q;

    lsu_lane_align u_align (
        .mem_addr_i  (addr_q),
        .mem_wdata_i (wdata_q),
        .mem_wmask_i (wmask_q),
        .w_data_o    (w_data_o),
        .w_strb_o    (w_strb_o),
        .rd_op_i     (op_q),
        .rd_offset_i (offset_q),
        .r_data_i    (r_data_i),
        .load_data_o (reg_wdata_o)
    );

    // ======================================================================
    // outputs
    // ======================================================================
    assign mem_stall_o = (state_q != ST_IDLE);

    // one-cycle writeback on the r handshake
    assign reg_we_o    = r_valid_i && r_ready_o;
    assign reg_waddr_o = rd_q;
    assign commit_id_o = commit_q;

endmodule
